// ==== common/rotator_cfg.svh ====
// sizes for the weight rotator; ROT_KW_MAX must be odd and every maximum at least 2
`ifndef ROTATOR_CFG_SVH
`define ROTATOR_CFG_SVH

// output columns, one weight word each per input beat
`define ROT_COLS 4

// bits per weight word
`define ROT_WORD_W 8

// largest kernel width, odd
`define ROT_KW_MAX 7

// largest input-channel count
`define ROT_CI_MAX 8

// largest image-width count
`define ROT_XW_MAX 8

// largest number of replays of one bank
`define ROT_REPS_MAX 4

// words per column per bank, a packet must fit in one bank
`define ROT_RAM_DEPTH 64

`endif

// ==== common/rotator_pkg.sv ====
// types sized from rotator_cfg.svh; header fields sit from bit 0 up as kw2, cin, xw, reps
`default_nettype none

`include "rotator_cfg.svh"

package rotator_pkg;

  // one weight word and one full input beat, column 0 in the low bits
  typedef logic [`ROT_WORD_W-1:0]           word_t;
  typedef logic [`ROT_COLS*`ROT_WORD_W-1:0] beat_t;

  // address within one bank of one column
  typedef logic [$clog2(`ROT_RAM_DEPTH)-1:0] addr_t;

  // kernel half-width and position in the kernel
  typedef logic [$clog2((`ROT_KW_MAX+1)/2)-1:0] kw2_t;
  typedef logic [$clog2(`ROT_KW_MAX)-1:0]       kw_t;

  // counts stored minus one
  typedef logic [$clog2(`ROT_CI_MAX)-1:0]   cin_t;
  typedef logic [$clog2(`ROT_XW_MAX)-1:0]   xw_t;
  typedef logic [$clog2(`ROT_REPS_MAX)-1:0] reps_t;

  // ping-pong bank index
  typedef logic bank_t;

  // writer FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_GET_HDR,
    WR_WRITE,
    WR_SWITCH
  } wr_state_e;

  // per-column reader FSM
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_READ,
    RD_SWITCH
  } rd_state_e;

endpackage

`default_nettype wire

// ==== column_reader/weight_bank_ram.sv ====
// one column's storage, two banks of ROT_RAM_DEPTH words; read data lands one cycle after i_rd_en
`timescale 1ns/1ps
`default_nettype none

`include "rotator_cfg.svh"

module weight_bank_ram (
  input  wire logic                 aclk,
  input  wire logic                 i_wr_en,
  input  wire rotator_pkg::bank_t   i_wr_bank,
  input  wire rotator_pkg::addr_t   i_wr_addr,
  input  wire rotator_pkg::word_t   i_wr_data,
  input  wire logic                 i_rd_en,
  input  wire rotator_pkg::bank_t   i_rd_bank,
  input  wire rotator_pkg::addr_t   i_rd_addr,
  output rotator_pkg::word_t        o_rd_data
);

  import rotator_pkg::*;

  word_t mem [2][`ROT_RAM_DEPTH];

  // writer and reader never share a bank, so no collision handling
  always_ff @(posedge aclk) begin
    if (i_wr_en) begin
      mem[i_wr_bank][i_wr_addr] <= i_wr_data;
    end
  end

  // output register holds while the reader is stalled
  always_ff @(posedge aclk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_bank][i_rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== column_reader/rotation_counters.sv ====
// nested replay counters; header fields must stay stable from i_start until the last step
`timescale 1ns/1ps
`default_nettype none

module rotation_counters (
  input  wire logic                 aclk,
  input  wire logic                 aresetn,
  input  wire logic                 i_start,
  input  wire logic                 i_step,
  input  wire rotator_pkg::kw2_t    i_kw2,
  input  wire rotator_pkg::cin_t    i_cin_1,
  input  wire rotator_pkg::xw_t     i_cols_1,
  input  wire rotator_pkg::reps_t   i_reps_1,
  output logic                      o_first,
  output logic                      o_cin_last,
  output logic                      o_w_last,
  output logic                      o_last
);

  import rotator_pkg::*;

  kw_t   kw_cnt;
  cin_t  cin_cnt;
  xw_t   xw_cnt;
  reps_t reps_cnt;
  logic  kw_end;
  logic  cin_end;
  logic  xw_end;
  logic  reps_end;

  // kernel runs 0 to 2*kw2
  assign kw_end   = (kw_cnt == kw_t'(2 * i_kw2));
  assign cin_end  = (cin_cnt == i_cin_1);
  assign xw_end   = (xw_cnt == i_cols_1);
  assign reps_end = (reps_cnt == i_reps_1);

  always_ff @(posedge aclk) begin
    if (!aresetn || i_start) begin
      kw_cnt   <= '0;
      cin_cnt  <= '0;
      xw_cnt   <= '0;
      reps_cnt <= '0;
    end else if (i_step) begin
      kw_cnt <= kw_end ? '0 : kw_cnt + 1'b1;
      // each wrap carries into the next level
      if (kw_end) begin
        cin_cnt <= cin_end ? '0 : cin_cnt + 1'b1;
      end
      if (kw_end && cin_end) begin
        xw_cnt <= xw_end ? '0 : xw_cnt + 1'b1;
      end
      if (kw_end && cin_end && xw_end) begin
        reps_cnt <= reps_end ? '0 : reps_cnt + 1'b1;
      end
    end
  end

  assign o_first    = (kw_cnt == '0) && (cin_cnt == '0) && (xw_cnt == '0);
  assign o_cin_last = kw_end && cin_end;
  assign o_w_last   = xw_end;
  assign o_last     = kw_end && cin_end && xw_end && reps_end;

endmodule

`default_nettype wire

// ==== column_reader/column_reader.sv ====
// one output column; replays its own bank with a two-entry buffer, first word two cycles after READ
`timescale 1ns/1ps
`default_nettype none

`include "rotator_cfg.svh"

module column_reader #(
  parameter int COL_IDX = 0
) (
  input  wire logic                   aclk,
  input  wire logic                   aresetn,
  input  wire logic [1:0]             i_bank_full,
  input  wire rotator_pkg::kw2_t [1:0]  i_kw2,
  input  wire rotator_pkg::cin_t [1:0]  i_cin_1,
  input  wire rotator_pkg::xw_t [1:0]   i_cols_1,
  input  wire rotator_pkg::reps_t [1:0] i_reps_1,
  input  wire rotator_pkg::addr_t [1:0] i_addr_max,
  input  wire logic                   i_wr_en,
  input  wire rotator_pkg::bank_t     i_wr_bank,
  input  wire rotator_pkg::addr_t     i_wr_addr,
  input  wire rotator_pkg::beat_t     i_wr_data,
  output logic [1:0]                  o_bank_free,
  output logic                        o_m_valid,
  input  wire logic                   i_m_ready,
  output rotator_pkg::word_t          o_m_data,
  output logic                        o_m_last,
  output logic                        o_m_first,
  output logic                        o_m_cin_last,
  output logic                        o_m_w_last
);

  import rotator_pkg::*;

  rd_state_e  state;
  bank_t      rd_bank;
  logic [1:0] rd_done;
  addr_t      rd_addr;
  logic       issued_all;
  logic       start;
  logic       rd_en;
  logic       pop;
  logic       ram_vld;
  word_t      ram_data;
  logic       cnt_first;
  logic       cnt_cin_last;
  logic       cnt_w_last;
  logic       cnt_last;
  logic [3:0] flags_q;
  word_t      buf_data [2];
  logic [3:0] buf_flags [2];
  logic       buf_wr_ptr;
  logic       buf_rd_ptr;
  logic [1:0] buf_cnt;
  logic [2:0] slots_used;

  // rd_done stops a second replay of a bank the writer has not refilled yet
  assign start = (state == RD_IDLE) && i_bank_full[rd_bank] && !rd_done[rd_bank];
  assign pop   = o_m_valid && i_m_ready;

  // buffer entries plus the read in flight, after this cycle's pop
  assign slots_used = {1'b0, buf_cnt} + {2'b00, ram_vld} - {2'b00, pop};
  assign rd_en      = (state == RD_READ) && !issued_all && (slots_used < 3'd2);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state       <= RD_IDLE;
      rd_bank     <= 1'b0;
      rd_done     <= 2'b00;
      o_bank_free <= 2'b11;
      rd_addr     <= '0;
      issued_all  <= 1'b0;
      ram_vld     <= 1'b0;
    end else begin
      ram_vld <= rd_en;
      rd_done <= rd_done & i_bank_full;
      case (state)
        RD_IDLE: begin
          if (start) begin
            state                <= RD_READ;
            o_bank_free[rd_bank] <= 1'b0;
            rd_addr              <= '0;
            issued_all           <= 1'b0;
          end
        end
        RD_READ: begin
          if (rd_en) begin
            // cyclic read over the written words
            rd_addr <= (rd_addr == i_addr_max[rd_bank]) ? '0 : rd_addr + 1'b1;
            if (cnt_last) begin
              issued_all <= 1'b1;
            end
          end
          if (pop && buf_flags[buf_rd_ptr][3]) begin
            state <= RD_SWITCH;
          end
        end
        RD_SWITCH: begin
          o_bank_free[rd_bank] <= 1'b1;
          rd_done[rd_bank]     <= 1'b1;
          rd_bank              <= ~rd_bank;
          state                <= RD_IDLE;
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  weight_bank_ram u_weight_bank_ram (
    .aclk       (aclk),
    .i_wr_en    (i_wr_en),
    .i_wr_bank  (i_wr_bank),
    .i_wr_addr  (i_wr_addr),
    .i_wr_data  (i_wr_data[COL_IDX*`ROT_WORD_W +: `ROT_WORD_W]),
    .i_rd_en    (rd_en),
    .i_rd_bank  (rd_bank),
    .i_rd_addr  (rd_addr),
    .o_rd_data  (ram_data)
  );

  rotation_counters u_rotation_counters (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_start     (start),
    .i_step      (rd_en),
    .i_kw2       (i_kw2[rd_bank]),
    .i_cin_1     (i_cin_1[rd_bank]),
    .i_cols_1    (i_cols_1[rd_bank]),
    .i_reps_1    (i_reps_1[rd_bank]),
    .o_first     (cnt_first),
    .o_cin_last  (cnt_cin_last),
    .o_w_last    (cnt_w_last),
    .o_last      (cnt_last)
  );

  // flags follow the word through the RAM register
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      flags_q <= {cnt_last, cnt_w_last, cnt_cin_last, cnt_first};
    end
  end

  // two-entry output buffer
  always_ff @(posedge aclk) begin
    if (ram_vld) begin
      buf_data[buf_wr_ptr]  <= ram_data;
      buf_flags[buf_wr_ptr] <= flags_q;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      buf_wr_ptr <= 1'b0;
      buf_rd_ptr <= 1'b0;
      buf_cnt    <= 2'd0;
    end else begin
      if (ram_vld) begin
        buf_wr_ptr <= ~buf_wr_ptr;
      end
      if (pop) begin
        buf_rd_ptr <= ~buf_rd_ptr;
      end
      buf_cnt <= buf_cnt + {1'b0, ram_vld} - {1'b0, pop};
    end
  end

  assign o_m_valid    = (buf_cnt != 2'd0);
  assign o_m_data     = buf_data[buf_rd_ptr];
  assign o_m_last     = o_m_valid && buf_flags[buf_rd_ptr][3];
  assign o_m_w_last   = buf_flags[buf_rd_ptr][2];
  assign o_m_cin_last = buf_flags[buf_rd_ptr][1];
  assign o_m_first    = buf_flags[buf_rd_ptr][0];

  // a stalled beat holds its word and flags until taken
  a_hold_on_stall : assert property (
    @(posedge aclk) disable iff (!aresetn)
    (o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_data) &&
      $stable({o_m_last, o_m_first, o_m_cin_last, o_m_w_last}))
  );

endmodule

`default_nettype wire

// ==== source/weight_loader.sv ====
// writer side; header beat first, then weight beats up to tlast; needs at least one weight beat
`timescale 1ns/1ps
`default_nettype none

`include "rotator_cfg.svh"

module weight_loader (
  input  wire logic                   aclk,
  input  wire logic                   aresetn,
  input  wire logic                   i_s_valid,
  output logic                        o_s_ready,
  input  wire rotator_pkg::beat_t     i_s_data,
  input  wire logic                   i_s_last,
  input  wire logic [1:0]             i_bank_free,
  output logic [1:0]                  o_bank_full,
  output rotator_pkg::kw2_t [1:0]     o_kw2,
  output rotator_pkg::cin_t [1:0]     o_cin_1,
  output rotator_pkg::xw_t [1:0]      o_cols_1,
  output rotator_pkg::reps_t [1:0]    o_reps_1,
  output rotator_pkg::addr_t [1:0]    o_addr_max,
  output logic                        o_wr_en,
  output rotator_pkg::bank_t          o_wr_bank,
  output rotator_pkg::addr_t          o_wr_addr,
  output rotator_pkg::beat_t          o_wr_data
);

  import rotator_pkg::*;

  // header field positions, packed from bit 0 upward
  localparam int KW2_LSB  = 0;
  localparam int CIN_LSB  = KW2_LSB + $bits(kw2_t);
  localparam int XW_LSB   = CIN_LSB + $bits(cin_t);
  localparam int REPS_LSB = XW_LSB + $bits(xw_t);

  wr_state_e state;
  bank_t     wr_bank;
  addr_t     wr_addr;
  logic      s_hs;

  assign o_s_ready = (state == WR_GET_HDR) || (state == WR_WRITE);
  assign s_hs      = i_s_valid && o_s_ready;

  // write FSM with the bank-full flags and the write pointer
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state       <= WR_IDLE;
      wr_bank     <= 1'b0;
      wr_addr     <= '0;
      o_bank_full <= 2'b00;
    end else begin
      case (state)
        WR_IDLE: begin
          // wait until every column has let go of this bank
          if (i_bank_free[wr_bank]) begin
            state                <= WR_GET_HDR;
            o_bank_full[wr_bank] <= 1'b0;
          end
        end
        WR_GET_HDR: begin
          if (s_hs) begin
            state   <= WR_WRITE;
            wr_addr <= '0;
          end
        end
        WR_WRITE: begin
          if (s_hs) begin
            wr_addr <= wr_addr + 1'b1;
            if (i_s_last) begin
              state <= WR_SWITCH;
            end
          end
        end
        WR_SWITCH: begin
          o_bank_full[wr_bank] <= 1'b1;
          wr_bank              <= ~wr_bank;
          state                <= WR_IDLE;
        end
        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  // per-bank header and last address, held while the readers replay
  always_ff @(posedge aclk) begin
    if (state == WR_GET_HDR && s_hs) begin
      o_kw2[wr_bank]    <= i_s_data[KW2_LSB +: $bits(kw2_t)];
      o_cin_1[wr_bank]  <= i_s_data[CIN_LSB +: $bits(cin_t)];
      o_cols_1[wr_bank] <= i_s_data[XW_LSB +: $bits(xw_t)];
      o_reps_1[wr_bank] <= i_s_data[REPS_LSB +: $bits(reps_t)];
    end
    if (state == WR_WRITE && s_hs && i_s_last) begin
      o_addr_max[wr_bank] <= wr_addr;
    end
  end

  // shared write strobe, each column keeps its own slice
  assign o_wr_en   = (state == WR_WRITE) && s_hs;
  assign o_wr_bank = wr_bank;
  assign o_wr_addr = wr_addr;
  assign o_wr_data = i_s_data;

  // a packet longer than one bank would overwrite its own first words
  a_no_addr_wrap : assert property (
    @(posedge aclk) disable iff (!aresetn)
    (state == WR_WRITE && s_hs && !i_s_last) |-> (wr_addr != addr_t'(`ROT_RAM_DEPTH - 1))
  );

endmodule

`default_nettype wire

// ==== source/weight_rotator.sv ====
// top level; every packet needs a header beat and at least one weight beat, at most ROT_RAM_DEPTH
`timescale 1ns/1ps
`default_nettype none

`include "rotator_cfg.svh"

module weight_rotator (
  input  wire logic                                       aclk,
  input  wire logic                                       aresetn,
  input  wire logic                                       i_s_valid,
  output logic                                            o_s_ready,
  input  wire rotator_pkg::beat_t                         i_s_data,
  input  wire logic                                       i_s_last,
  input  wire logic [`ROT_COLS-1:0]                       i_m_ready,
  output logic [`ROT_COLS-1:0]                            o_m_valid,
  output rotator_pkg::word_t [`ROT_COLS-1:0]              o_m_data,
  output logic [`ROT_COLS-1:0]                            o_m_last,
  output logic [`ROT_COLS-1:0]                            o_m_first,
  output logic [`ROT_COLS-1:0]                            o_m_cin_last,
  output logic [`ROT_COLS-1:0]                            o_m_w_last
);

  import rotator_pkg::*;

  logic [1:0]                 bank_full;
  logic [1:0]                 bank_free;
  logic [`ROT_COLS-1:0][1:0]  col_free;
  kw2_t [1:0]                 kw2;
  cin_t [1:0]                 cin_1;
  xw_t [1:0]                  cols_1;
  reps_t [1:0]                reps_1;
  addr_t [1:0]                addr_max;
  logic                       wr_en;
  bank_t                      wr_bank;
  addr_t                      wr_addr;
  beat_t                      wr_data;

  // a bank is free only once every column has released it
  always_comb begin
    bank_free = 2'b11;
    for (int c = 0; c < `ROT_COLS; c++) begin
      bank_free = bank_free & col_free[c];
    end
  end

  weight_loader u_weight_loader (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .i_s_valid    (i_s_valid),
    .o_s_ready    (o_s_ready),
    .i_s_data     (i_s_data),
    .i_s_last     (i_s_last),
    .i_bank_free  (bank_free),
    .o_bank_full  (bank_full),
    .o_kw2        (kw2),
    .o_cin_1      (cin_1),
    .o_cols_1     (cols_1),
    .o_reps_1     (reps_1),
    .o_addr_max   (addr_max),
    .o_wr_en      (wr_en),
    .o_wr_bank    (wr_bank),
    .o_wr_addr    (wr_addr),
    .o_wr_data    (wr_data)
  );

  for (genvar c = 0; c < `ROT_COLS; c++) begin : g_col
    column_reader #(
      .COL_IDX (c)
    ) u_column_reader (
      .aclk          (aclk),
      .aresetn       (aresetn),
      .i_bank_full   (bank_full),
      .i_kw2         (kw2),
      .i_cin_1       (cin_1),
      .i_cols_1      (cols_1),
      .i_reps_1      (reps_1),
      .i_addr_max    (addr_max),
      .i_wr_en       (wr_en),
      .i_wr_bank     (wr_bank),
      .i_wr_addr     (wr_addr),
      .i_wr_data     (wr_data),
      .o_bank_free   (col_free[c]),
      .o_m_valid     (o_m_valid[c]),
      .i_m_ready     (i_m_ready[c]),
      .o_m_data      (o_m_data[c]),
      .o_m_last      (o_m_last[c]),
      .o_m_first     (o_m_first[c]),
      .o_m_cin_last  (o_m_cin_last[c]),
      .o_m_w_last    (o_m_w_last[c])
    );
  end

endmodule

`default_nettype wire

// ==== test/tb_weight_rotator.sv ====
// self-checking testbench; needs simulator timing support, random packets stay within one bank
`timescale 1ns/1ps
`default_nettype none

`include "rotator_cfg.svh"

module tb_weight_rotator;

  import rotator_pkg::*;

  localparam int MAX_PKTS   = 16;
  localparam int TIMEOUT    = 20000;
  localparam int SAMPLE_DLY = 4;
  localparam int W          = `ROT_WORD_W;
  // header field positions, kw2 at bit 0 then cin, xw, reps
  localparam int HDR_CIN    = $bits(kw2_t);
  localparam int HDR_XW     = HDR_CIN + $bits(cin_t);
  localparam int HDR_REPS   = HDR_XW + $bits(xw_t);

  logic                   aclk;
  logic                   aresetn;
  logic                   i_s_valid;
  logic                   o_s_ready;
  beat_t                  i_s_data;
  logic                   i_s_last;
  logic [`ROT_COLS-1:0]   i_m_ready;
  logic [`ROT_COLS-1:0]   o_m_valid;
  word_t [`ROT_COLS-1:0]  o_m_data;
  logic [`ROT_COLS-1:0]   o_m_last;
  logic [`ROT_COLS-1:0]   o_m_first;
  logic [`ROT_COLS-1:0]   o_m_cin_last;
  logic [`ROT_COLS-1:0]   o_m_w_last;

  // packets as sent, kept for the reference
  beat_t pkt_words [MAX_PKTS][`ROT_RAM_DEPTH];
  int    pkt_kw2 [MAX_PKTS];
  int    pkt_cin_1 [MAX_PKTS];
  int    pkt_cols_1 [MAX_PKTS];
  int    pkt_reps_1 [MAX_PKTS];
  int    pkts_made;
  // per column, packet and beat expected next
  int    col_pkt [`ROT_COLS];
  int    col_beat [`ROT_COLS];
  // 0 all low, 1 all high, 2 random per column
  int    ready_mode;

  weight_rotator u_weight_rotator (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .i_s_valid     (i_s_valid),
    .o_s_ready     (o_s_ready),
    .i_s_data      (i_s_data),
    .i_s_last      (i_s_last),
    .i_m_ready     (i_m_ready),
    .o_m_valid     (o_m_valid),
    .o_m_data      (o_m_data),
    .o_m_last      (o_m_last),
    .o_m_first     (o_m_first),
    .o_m_cin_last  (o_m_cin_last),
    .o_m_w_last    (o_m_w_last)
  );

  initial begin : clock_gen
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERR time %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  // expected {last, w_last, cin_last, first, word} for beat n of a packet on one column
  function automatic logic [`ROT_WORD_W+3:0] expect_beat(input int col, input int pkt,
                                                         input int n);
    int    k_len;
    int    c_len;
    int    x_len;
    int    total;
    int    kw;
    int    ci;
    int    xw;
    logic  is_first;
    logic  is_cin_last;
    logic  is_w_last;
    logic  is_last;
    word_t word;
    k_len       = 2 * pkt_kw2[pkt] + 1;
    c_len       = pkt_cin_1[pkt] + 1;
    x_len       = pkt_cols_1[pkt] + 1;
    total       = k_len * c_len * x_len * (pkt_reps_1[pkt] + 1);
    kw          = n % k_len;
    ci          = (n / k_len) % c_len;
    xw          = (n / (k_len * c_len)) % x_len;
    // cyclic over the written words
    word        = pkt_words[pkt][n % (k_len * c_len)][col * W +: W];
    is_first    = (kw == 0) && (ci == 0) && (xw == 0);
    is_cin_last = (kw == k_len - 1) && (ci == c_len - 1);
    is_w_last   = (xw == x_len - 1);
    is_last     = (n == total - 1);
    return {is_last, is_w_last, is_cin_last, is_first, word};
  endfunction

  // sampled just before the rising edge, where every output is settled
  initial begin : compare_outputs
    logic [`ROT_WORD_W+3:0] exp_v;
    forever begin
      @(negedge aclk);
      #SAMPLE_DLY;
      for (int c = 0; c < `ROT_COLS; c++) begin
        if (aresetn && o_m_valid[c] && i_m_ready[c]) begin
          if (col_pkt[c] >= pkts_made) begin
            fail_run($sformatf("column %0d sent a beat with no packet loaded", c));
          end
          exp_v = expect_beat(c, col_pkt[c], col_beat[c]);
          check_value($sformatf("o_m_data[%0d]", c), 32'(o_m_data[c]), 32'(exp_v[W-1:0]));
          check_value($sformatf("o_m_first[%0d]", c), 32'(o_m_first[c]), 32'(exp_v[W]));
          check_value($sformatf("o_m_cin_last[%0d]", c), 32'(o_m_cin_last[c]),
                      32'(exp_v[W+1]));
          check_value($sformatf("o_m_w_last[%0d]", c), 32'(o_m_w_last[c]), 32'(exp_v[W+2]));
          check_value($sformatf("o_m_last[%0d]", c), 32'(o_m_last[c]), 32'(exp_v[W+3]));
          if (exp_v[W+3]) begin
            col_pkt[c]  = col_pkt[c] + 1;
            col_beat[c] = 0;
          end else begin
            col_beat[c] = col_beat[c] + 1;
          end
        end
      end
    end
  end

  initial begin : drive_ready
    i_m_ready = '0;
    forever begin
      @(negedge aclk);
      for (int c = 0; c < `ROT_COLS; c++) begin
        if (ready_mode == 2) begin
          i_m_ready[c] = ($urandom % 4) != 0;
        end else begin
          i_m_ready[c] = (ready_mode == 1);
        end
      end
    end
  end

  task automatic make_packet(output int idx);
    int    words;
    beat_t b;
    idx             = pkts_made;
    pkt_kw2[idx]    = int'($urandom % ((`ROT_KW_MAX + 1) / 2));
    pkt_cin_1[idx]  = int'($urandom % `ROT_CI_MAX);
    pkt_cols_1[idx] = int'($urandom % `ROT_XW_MAX);
    pkt_reps_1[idx] = int'($urandom % `ROT_REPS_MAX);
    words           = (2 * pkt_kw2[idx] + 1) * (pkt_cin_1[idx] + 1);
    for (int a = 0; a < words; a++) begin
      for (int c = 0; c < `ROT_COLS; c++) begin
        b[c * W +: W] = word_t'($urandom);
      end
      pkt_words[idx][a] = b;
    end
    pkts_made = pkts_made + 1;
  endtask

  // unused header bits carry a nonzero pattern
  function automatic beat_t header_beat(input int idx);
    beat_t hdr;
    for (int c = 0; c < `ROT_COLS; c++) begin
      hdr[c * W +: W] = word_t'(idx * 37 + c * 11 + 90);
    end
    hdr[0 +: $bits(kw2_t)]         = kw2_t'(pkt_kw2[idx]);
    hdr[HDR_CIN +: $bits(cin_t)]   = cin_t'(pkt_cin_1[idx]);
    hdr[HDR_XW +: $bits(xw_t)]     = xw_t'(pkt_cols_1[idx]);
    hdr[HDR_REPS +: $bits(reps_t)] = reps_t'(pkt_reps_1[idx]);
    return hdr;
  endfunction

  // called on a falling edge, returns on the falling edge after the handshake
  task automatic send_beat(input beat_t data, input logic last);
    int waited;
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_last  = last;
    waited    = 0;
    while (!o_s_ready) begin
      @(negedge aclk);
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        fail_run("timeout: input stream was never accepted");
      end
    end
    @(negedge aclk);
  endtask

  task automatic send_packet(input int idx);
    int words;
    words = (2 * pkt_kw2[idx] + 1) * (pkt_cin_1[idx] + 1);
    send_beat(header_beat(idx), 1'b0);
    for (int a = 0; a < words; a++) begin
      send_beat(pkt_words[idx][a], a == words - 1);
    end
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
  endtask

  task automatic wait_columns(input int npkts);
    int   waited;
    logic all_done;
    waited   = 0;
    all_done = 1'b0;
    while (!all_done) begin
      @(negedge aclk);
      waited   = waited + 1;
      all_done = 1'b1;
      for (int c = 0; c < `ROT_COLS; c++) begin
        if (col_pkt[c] < npkts) begin
          all_done = 1'b0;
        end
      end
      if (!all_done && waited > TIMEOUT) begin
        fail_run($sformatf("timeout: columns did not finish %0d packets", npkts));
      end
    end
  endtask

  initial begin : main_seq
    int    seed_ret;
    int    p;
    beat_t hdr;
    seed_ret   = $urandom(32'h13c9309c);
    aresetn    = 1'b0;
    i_s_valid  = 1'b0;
    i_s_data   = '0;
    i_s_last   = 1'b0;
    ready_mode = 0;
    pkts_made  = 0;
    repeat (16) @(negedge aclk);
    check_value("o_s_ready", 32'(o_s_ready), 32'd0);
    check_value("o_m_valid", 32'(o_m_valid), 32'd0);
    check_value("o_m_last", 32'(o_m_last), 32'd0);
    aresetn = 1'b1;

    // single packet, no back-pressure
    ready_mode = 1;
    make_packet(p);
    send_packet(p);
    wait_columns(1);

    // back-to-back packets fill the two banks in turn
    for (int i = 0; i < 2; i++) begin
      make_packet(p);
      send_packet(p);
    end
    wait_columns(3);

    // independent random stalls per column
    ready_mode = 2;
    for (int i = 0; i < 3; i++) begin
      make_packet(p);
      send_packet(p);
    end
    wait_columns(6);

    // outputs blocked, both banks fill and the third packet has to wait
    ready_mode = 0;
    for (int i = 0; i < 2; i++) begin
      make_packet(p);
      send_packet(p);
    end
    make_packet(p);
    hdr       = header_beat(p);
    i_s_valid = 1'b1;
    i_s_data  = hdr;
    i_s_last  = 1'b0;
    repeat (20) begin
      check_value("o_s_ready", 32'(o_s_ready), 32'd0);
      @(negedge aclk);
    end
    ready_mode = 1;
    send_packet(p);
    wait_columns(9);

    // nothing left over once every packet is out
    repeat (8) @(negedge aclk);
    check_value("o_m_valid", 32'(o_m_valid), 32'd0);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/rotator_pkg.sv
column_reader/weight_bank_ram.sv
column_reader/rotation_counters.sv
column_reader/column_reader.sv
source/weight_loader.sv
source/weight_rotator.sv
test/tb_weight_rotator.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the weight rotator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_weight_rotator \
  -Mdir obj_dir

# the log decides the result, so a stopped run must not end the script here
./obj_dir/Vtb_weight_rotator > sim.log 2>&1 || true
cat sim.log

if grep -q 'Test failures found' sim.log; then
  echo "simulation reported errors"
  exit 1
fi
if ! grep -q 'All tests passed!' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation clean"
